// ==== vlog.f ====
verilog/adc_frontend_pkg.sv
verilog/adc_sample_path.sv
verilog/adc_level_trigger.sv
verilog/amp_gain_pwm.sv
verilog/heartbeat_led.sv
verilog/adc_frontend_top.sv
tb/tb_adc_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the adc front end testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Errors found"

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f vlog.f --top-module tb_adc_frontend \
   -Mdir obj_dir -o tb_adc_frontend
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/tb_adc_frontend > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# the log decides, a crash without the message still counts as a failure
if grep -q "$FAIL_MSG" "$LOG"; then
   echo "simulation reported a failure"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

echo "simulation passed"
exit 0

// ==== tb/tb_adc_frontend.sv ====
`timescale 1ns/100ps

module tb_adc_frontend;

   logic                          clk_usb;
   logic                          reset;
   logic                          adc_valid_i;
   adc_frontend_pkg::adc_sample_t adc_data_i;
   logic                          source_adc_i;
   adc_frontend_pkg::trig_level_t trigger_level_i;
   logic                          armed_and_ready_i;
   adc_frontend_pkg::gain_t       gain_i;
   adc_frontend_pkg::led_mode_t   led_select_i;
   logic                          armed_i;
   logic                          capture_active_i;

   logic                          adc_sample_valid_o;
   adc_frontend_pkg::adc_sample_t adc_sample_o;
   logic                          trigger_adc_o;
   logic                          amp_gain_o;
   logic                          freq_measure_o;
   logic                          flash_pattern_o;
   logic                          led_armed_o;
   logic                          led_capture_o;

   int                            cycle_count;
   logic [31:0]                   lcg_state;
   adc_frontend_pkg::adc_sample_t exp_q[$];   // expected adc samples
   int                            issue_q[$]; // strobe cycle of each

   adc_frontend_top #(
      .pTIMER_WIDTH (8)
   ) dut_i (
      .clk_usb            (clk_usb),
      .reset              (reset),
      .adc_valid_i        (adc_valid_i),
      .adc_data_i         (adc_data_i),
      .source_adc_i       (source_adc_i),
      .adc_sample_valid_o (adc_sample_valid_o),
      .adc_sample_o       (adc_sample_o),
      .trigger_level_i    (trigger_level_i),
      .armed_and_ready_i  (armed_and_ready_i),
      .trigger_adc_o      (trigger_adc_o),
      .gain_i             (gain_i),
      .amp_gain_o         (amp_gain_o),
      .led_select_i       (led_select_i),
      .armed_i            (armed_i),
      .capture_active_i   (capture_active_i),
      .freq_measure_o     (freq_measure_o),
      .flash_pattern_o    (flash_pattern_o),
      .led_armed_o        (led_armed_o),
      .led_capture_o      (led_capture_o)
   );

   initial clk_usb = 1'b0;
   always #10 clk_usb = ~clk_usb;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic stop_on_error();
      $display("Errors found");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic value_fail(input string msg);
      $display("[FAIL] %0t: %s", $time, msg);
      stop_on_error();
   endtask

   task automatic timeout_fail(input string msg);
      $display("timeout, %s", msg);
      stop_on_error();
   endtask

   // inputs change 1 ns after the edge, registered outputs are settled by then
   task automatic tick();
      @(posedge clk_usb);
      #1;
      cycle_count = cycle_count + 1;
   endtask

   task automatic wait_sample_valid(input int max_cycles);
      int n;
      n = 0;
      do begin
         tick();
         n++;
      end while (!adc_sample_valid_o && n < max_cycles);
      if (!adc_sample_valid_o) begin
         timeout_fail($sformatf("no sample valid within %0d cycles", max_cycles));
      end
   endtask

   task automatic reset_values_check();
      assert (!trigger_adc_o && !adc_sample_valid_o && !amp_gain_o)
         else value_fail("sample, trigger or gain output high after reset");
      assert (!freq_measure_o && !flash_pattern_o)
         else value_fail("heartbeat output high after reset");
   endtask

   task automatic test_pattern_check();
      source_adc_i = 1'b0;
      adc_valid_i = 1'b1;
      for (int i = 0; i < 10; i++) begin
         tick();
         adc_valid_i = 1'b0;
         assert (!adc_sample_valid_o) else value_fail("sample valid longer than one cycle");
         wait_sample_valid(4);
         assert (adc_sample_o == 12'(i))
            else value_fail($sformatf("pattern sample %0d read %h", i, adc_sample_o));
         if (i < 9) begin
            adc_valid_i = 1'b1; // next strobe, one idle cycle between
         end
      end
      tick();
      assert (!adc_sample_valid_o) else value_fail("sample valid longer than one cycle");
   endtask

   task automatic adc_out_check();
      int lat;
      adc_frontend_pkg::adc_sample_t exp;
      if (adc_sample_valid_o) begin
         assert (exp_q.size() > 0) else value_fail("sample valid with no strobe pending");
         exp = exp_q.pop_front();
         lat = cycle_count - issue_q.pop_front();
         assert (lat == 2) else value_fail($sformatf("adc sample latency %0d", lat));
         assert (adc_sample_o == exp)
            else value_fail($sformatf("adc sample %h, expected %h", adc_sample_o, exp));
      end
   endtask

   task automatic adc_latency_check();
      int n;
      source_adc_i = 1'b1;
      for (int k = 0; k < 8; k++) begin
         lcg_state = lcg_next(lcg_state);
         adc_valid_i = 1'b1;
         adc_data_i = lcg_state[27:16];
         exp_q.push_back(lcg_state[27:16]);
         issue_q.push_back(cycle_count);
         tick();
         adc_out_check();
      end
      adc_valid_i = 1'b0;
      n = 0;
      while (exp_q.size() > 0 && n < 10) begin
         tick();
         adc_out_check();
         n++;
      end
      if (exp_q.size() > 0) begin
         timeout_fail("adc samples still missing after 10 cycles");
      end
   endtask

   task automatic arm_set(input logic level);
      armed_and_ready_i = level;
      tick();
      tick();
   endtask

   // one sample through the pipeline, trigger looked at one cycle after valid
   task automatic sample_trigger_check(input adc_frontend_pkg::adc_sample_t value,
                                       input logic expect_fire);
      int n;
      adc_valid_i = 1'b1;
      adc_data_i = value;
      tick();
      adc_valid_i = 1'b0;
      n = 0;
      while (!adc_sample_valid_o && n < 8) begin
         assert (!trigger_adc_o) else value_fail("trigger with no sample");
         tick();
         n++;
      end
      if (!adc_sample_valid_o) begin
         timeout_fail("sample for the trigger never became valid");
      end
      assert (!trigger_adc_o) else value_fail("trigger in the sample valid cycle");
      tick();
      assert (trigger_adc_o == expect_fire)
         else value_fail($sformatf("sample %h gave trigger %b", value, trigger_adc_o));
      tick();
      assert (!trigger_adc_o) else value_fail("trigger longer than one cycle");
   endtask

   task automatic high_trigger_check();
      source_adc_i = 1'b1;
      trigger_level_i = 12'h900;
      arm_set(1'b1);
      sample_trigger_check(12'h100, 1'b0);
      sample_trigger_check(12'h900, 1'b0); // equal, strict compare
      sample_trigger_check(12'h901, 1'b1);
      sample_trigger_check(12'hf00, 1'b0); // one shot spent
      sample_trigger_check(12'ha00, 1'b0);
      arm_set(1'b0);
      arm_set(1'b1);
      sample_trigger_check(12'hb00, 1'b1);
      arm_set(1'b0);
   endtask

   task automatic low_trigger_check();
      trigger_level_i = 12'h400;
      sample_trigger_check(12'h050, 1'b0); // never armed
      arm_set(1'b1);
      sample_trigger_check(12'h600, 1'b0);
      sample_trigger_check(12'h400, 1'b0);
      sample_trigger_check(12'h3ff, 1'b1);
      sample_trigger_check(12'h000, 1'b0);
      arm_set(1'b0);
   endtask

   task automatic gain_pwm_check();
      int gains[4];
      int count;
      gains = '{0, 1, 77, 255};
      for (int k = 0; k < 4; k++) begin
         gain_i = 8'(gains[k]);
         count = 0;
         repeat (256) begin
            tick();
            if (amp_gain_o) begin
               count++;
            end
         end
         assert (count == gains[k])
            else value_fail($sformatf("gain %0d gave %0d high cycles", gains[k], count));
      end
      gain_i = '0;
   endtask

   task automatic wait_freq_pulse(output int pulse_cycle);
      int n;
      n = 0;
      do begin
         tick();
         n++;
      end while (!freq_measure_o && n < 40);
      if (!freq_measure_o) begin
         timeout_fail("no frequency measure pulse within 40 cycles");
      end
      pulse_cycle = cycle_count;
      tick();
      assert (!freq_measure_o) else value_fail("frequency measure pulse too long");
   endtask

   task automatic status_led_check(input adc_frontend_pkg::led_mode_t mode,
                                   input logic armed,
                                   input logic capture);
      led_select_i = mode;
      armed_i = armed;
      capture_active_i = capture;
      #1;
      assert (led_armed_o == armed && led_capture_o == capture)
         else value_fail($sformatf("mode %0d leds %b%b", mode, led_armed_o, led_capture_o));
      tick();
   endtask

   task automatic wait_led_toggle(output int toggle_cycle);
      logic prev;
      int   n;
      prev = led_armed_o;
      n = 0;
      do begin
         tick();
         n++;
         assert (led_armed_o == led_capture_o) else value_fail("timer mode leds differ");
      end while (led_armed_o == prev && n < 80);
      if (led_armed_o == prev) begin
         timeout_fail("timer mode leds did not toggle within 80 cycles");
      end
      toggle_cycle = cycle_count;
   endtask

   task automatic heartbeat_check();
      int modes[3];
      int t_prev;
      int t_next;
      modes = '{0, 2, 3};
      wait_freq_pulse(t_prev);
      for (int k = 0; k < 3; k++) begin
         wait_freq_pulse(t_next);
         assert (t_next - t_prev == 32)
            else value_fail($sformatf("freq pulses %0d cycles apart", t_next - t_prev));
         t_prev = t_next;
      end
      for (int m = 0; m < 3; m++) begin
         for (int c = 0; c < 4; c++) begin
            status_led_check(2'(modes[m]), c[1], c[0]);
         end
      end
      led_select_i = adc_frontend_pkg::LED_MODE_TIMER;
      #1;
      wait_led_toggle(t_prev);
      for (int k = 0; k < 2; k++) begin
         wait_led_toggle(t_next);
         assert (t_next - t_prev == 64)
            else value_fail($sformatf("leds toggled %0d cycles apart", t_next - t_prev));
         t_prev = t_next;
      end
      led_select_i = adc_frontend_pkg::LED_MODE_STATUS;
   endtask

   // 8 bit timer starts from zero once the 4 reset cycles are over
   task automatic flash_check();
      logic [7:0] timer_exp;
      logic       flash_exp;
      logic       reloaded;
      flash_exp = 1'b0;
      reloaded = 1'b0;
      repeat (256) begin
         timer_exp = 8'(cycle_count - 4);
         if (timer_exp[7]) begin
            flash_exp = ~timer_exp[5]; // upper half reloads
            reloaded = 1'b1;
         end
         tick();
         if (reloaded) begin
            assert (flash_pattern_o == flash_exp)
               else value_fail($sformatf("flash pattern %b, expected %b",
                                         flash_pattern_o, flash_exp));
         end
      end
   endtask

   initial begin
      reset = 1'b1;
      adc_valid_i = 1'b0;
      adc_data_i = '0;
      source_adc_i = 1'b0;
      trigger_level_i = '0;
      armed_and_ready_i = 1'b0;
      gain_i = '0;
      led_select_i = adc_frontend_pkg::LED_MODE_STATUS;
      armed_i = 1'b0;
      capture_active_i = 1'b0;
      cycle_count = 0;
      lcg_state = 32'h7b97_907c;

      repeat (4) tick();
      reset = 1'b0;

      reset_values_check();
      test_pattern_check();
      adc_latency_check();
      high_trigger_check();
      low_trigger_check();
      gain_pwm_check();
      heartbeat_check();
      flash_check();

      $display("No errors");
      $finish;
   end

endmodule

// ==== verilog/adc_frontend_top.sv ====
`timescale 1ns/100ps

module adc_frontend_top #(
   parameter int pTIMER_WIDTH = 26
) (
   input  logic                          clk_usb,
   input  logic                          reset,

   // adc samples, one strobe per sample
   input  logic                          adc_valid_i,
   input  adc_frontend_pkg::adc_sample_t adc_data_i,
   input  logic                          source_adc_i,
   output logic                          adc_sample_valid_o,
   output adc_frontend_pkg::adc_sample_t adc_sample_o,

   // level trigger
   input  adc_frontend_pkg::trig_level_t trigger_level_i,
   input  logic                          armed_and_ready_i,
   output logic                          trigger_adc_o,

   input  adc_frontend_pkg::gain_t       gain_i,
   output logic                          amp_gain_o,

   // heartbeat and leds
   input  adc_frontend_pkg::led_mode_t   led_select_i,
   input  logic                          armed_i,
   input  logic                          capture_active_i,
   output logic                          freq_measure_o,
   output logic                          flash_pattern_o,
   output logic                          led_armed_o,
   output logic                          led_capture_o
);

   logic                          sample_valid;
   adc_frontend_pkg::adc_sample_t sample_data;

   adc_sample_path u_sample_path (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .adc_valid_i    (adc_valid_i),
      .adc_data_i     (adc_data_i),
      .source_adc_i   (source_adc_i),
      .sample_valid_o (sample_valid),
      .sample_o       (sample_data)
   );

   assign adc_sample_valid_o = sample_valid;
   assign adc_sample_o = sample_data;

   adc_level_trigger u_level_trigger (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .sample_valid_i    (sample_valid),
      .sample_i          (sample_data),
      .level_i           (trigger_level_i),
      .armed_and_ready_i (armed_and_ready_i),
      .trigger_o         (trigger_adc_o)
   );

   amp_gain_pwm u_amp_gain_pwm (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .gain_i     (gain_i),
      .amp_gain_o (amp_gain_o)
   );

   heartbeat_led #(
      .pTIMER_WIDTH (pTIMER_WIDTH)
   ) u_heartbeat_led (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .led_select_i     (led_select_i),
      .armed_i          (armed_i),
      .capture_active_i (capture_active_i),
      .freq_measure_o   (freq_measure_o),
      .flash_pattern_o  (flash_pattern_o),
      .led_armed_o      (led_armed_o),
      .led_capture_o    (led_capture_o)
   );

endmodule

// ==== verilog/heartbeat_led.sv ====
`timescale 1ns/100ps

module heartbeat_led #(
   parameter int pTIMER_WIDTH = 26
) (
   input  logic                        clk_usb,
   input  logic                        reset,
   input  adc_frontend_pkg::led_mode_t led_select_i,
   input  logic                        armed_i,
   input  logic                        capture_active_i,
   output logic                        freq_measure_o,
   output logic                        flash_pattern_o,
   output logic                        led_armed_o,
   output logic                        led_capture_o
);

   logic [pTIMER_WIDTH-1:0]     timer_heartbeat;
   logic                        measure_bit_q;
   adc_frontend_pkg::led_mode_t led_mode;

   // free running, bit W-4 paces the frequency strobe
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_heartbeat <= '0;
         measure_bit_q <= 1'b0;
         freq_measure_o <= 1'b0;
      end
      else begin
         timer_heartbeat <= timer_heartbeat + 1'b1;
         measure_bit_q <= timer_heartbeat[pTIMER_WIDTH-4];
         freq_measure_o <= timer_heartbeat[pTIMER_WIDTH-4] & ~measure_bit_q;
      end
   end

   // reload only in the upper half of the timer period
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         flash_pattern_o <= 1'b0;
      end
      else if (timer_heartbeat[pTIMER_WIDTH-1]) begin
         flash_pattern_o <= ~timer_heartbeat[pTIMER_WIDTH-3];
      end
   end

   // modes 2 and 3 fold onto the status view
   assign led_mode = (led_select_i == adc_frontend_pkg::LED_MODE_TIMER) ?
                     adc_frontend_pkg::LED_MODE_TIMER :
                     adc_frontend_pkg::LED_MODE_STATUS;

   always_comb begin
      if (led_mode == adc_frontend_pkg::LED_MODE_TIMER) begin
         led_armed_o = timer_heartbeat[pTIMER_WIDTH-2];
         led_capture_o = timer_heartbeat[pTIMER_WIDTH-2];
      end
      else begin
         led_armed_o = armed_i;
         led_capture_o = capture_active_i;
      end
   end

   a_freq_single_pulse: assert property (
      @(posedge clk_usb) disable iff (reset)
      freq_measure_o |=> !freq_measure_o
   );

endmodule

// ==== verilog/amp_gain_pwm.sv ====
`timescale 1ns/100ps

module amp_gain_pwm (
   input  logic                    clk_usb,
   input  logic                    reset,
   input  adc_frontend_pkg::gain_t gain_i,
   output logic                    amp_gain_o
);

   // one carry bit on top of the gain width
   logic [adc_frontend_pkg::GAIN_WIDTH:0] pwm_acc;

   // carry out every time the low bits wrap, gain_i times per 256 cycles
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwm_acc <= '0;
      end
      else begin
         pwm_acc <= {1'b0, pwm_acc[adc_frontend_pkg::GAIN_WIDTH-1:0]}
                    + {1'b0, gain_i};
      end
   end

   assign amp_gain_o = pwm_acc[adc_frontend_pkg::GAIN_WIDTH]; // registered carry

endmodule

// ==== verilog/adc_level_trigger.sv ====
`timescale 1ns/100ps

module adc_level_trigger (
   input  logic                          clk_usb,
   input  logic                          reset,
   input  logic                          sample_valid_i,
   input  adc_frontend_pkg::adc_sample_t sample_i,
   input  adc_frontend_pkg::trig_level_t level_i,
   input  logic                          armed_and_ready_i,
   output logic                          trigger_o
);

   adc_frontend_pkg::trig_state_t state;
   logic                          armed_and_ready_q;
   logic                          arm_rise;
   logic                          level_hit;
   logic                          fire_check;

   assign arm_rise = armed_and_ready_i & ~armed_and_ready_q;

   // level msb selects above / below
   always_comb begin
      if (level_i[adc_frontend_pkg::ADC_WIDTH-1]) begin
         level_hit = sample_i > level_i;
      end
      else begin
         level_hit = sample_i < level_i;
      end
   end

   // no second compare while the first pulse is still out
   assign fire_check = (state == adc_frontend_pkg::TRIG_ALLOWED) && sample_valid_i
                       && !trigger_o;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state <= adc_frontend_pkg::TRIG_IDLE;
         armed_and_ready_q <= 1'b0;
         trigger_o <= 1'b0;
      end
      else begin
         armed_and_ready_q <= armed_and_ready_i;

         if (fire_check) begin
            trigger_o <= level_hit;
         end
         else begin
            trigger_o <= 1'b0;
         end

         case (state)
            adc_frontend_pkg::TRIG_IDLE: begin
               if (arm_rise) begin
                  state <= adc_frontend_pkg::TRIG_ALLOWED;
               end
            end
            adc_frontend_pkg::TRIG_ALLOWED: begin
               if (trigger_o) begin
                  state <= adc_frontend_pkg::TRIG_IDLE; // one shot used up
               end
            end
            default: begin
               state <= adc_frontend_pkg::TRIG_IDLE;
            end
         endcase
      end
   end

   a_trigger_one_cycle: assert property (
      @(posedge clk_usb) disable iff (reset)
      trigger_o |=> !trigger_o
   );

endmodule

// ==== verilog/adc_sample_path.sv ====
`timescale 1ns/100ps

module adc_sample_path (
   input  logic                          clk_usb,
   input  logic                          reset,
   input  logic                          adc_valid_i,
   input  adc_frontend_pkg::adc_sample_t adc_data_i,
   input  logic                          source_adc_i,  // 0 = test counter
   output logic                          sample_valid_o,
   output adc_frontend_pkg::adc_sample_t sample_o
);

   adc_frontend_pkg::adc_sample_t test_count;
   adc_frontend_pkg::adc_sample_t sample_pre;
   adc_frontend_pkg::adc_sample_t sample_sel;
   logic                          valid_pre;

   assign sample_sel = source_adc_i ? adc_data_i : test_count;

   // counting pattern, steps once per accepted strobe
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         test_count <= '0;
      end
      else if (adc_valid_i) begin
         test_count <= test_count + 1'b1;
      end
   end

   // two stage resample, valid bits carry the strobe along
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         valid_pre <= 1'b0;
         sample_valid_o <= 1'b0;
      end
      else begin
         valid_pre <= adc_valid_i;
         sample_valid_o <= valid_pre;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (adc_valid_i) begin
         sample_pre <= sample_sel;
      end
      if (valid_pre) begin
         sample_o <= sample_pre;
      end
   end

   a_valid_known: assert property (
      @(posedge clk_usb) disable iff (reset)
      !$isunknown(sample_valid_o)
   );

endmodule

// ==== verilog/adc_frontend_pkg.sv ====
package adc_frontend_pkg;

   localparam int ADC_WIDTH = 12;
   localparam int GAIN_WIDTH = 8;
   localparam int LED_MODE_WIDTH = 2;

   typedef logic [ADC_WIDTH-1:0] adc_sample_t;

   // msb picks the compare: 1 fires above the level, 0 below
   typedef logic [ADC_WIDTH-1:0] trig_level_t;

   // pwm increment per clk_usb cycle
   typedef logic [GAIN_WIDTH-1:0] gain_t;

   typedef logic [LED_MODE_WIDTH-1:0] led_mode_t;

   localparam led_mode_t LED_MODE_STATUS = 2'd0; // armed / capture status
   localparam led_mode_t LED_MODE_TIMER = 2'd1;  // heartbeat on both leds

   // level trigger, one shot per arming
   typedef enum logic {
      TRIG_IDLE,
      TRIG_ALLOWED
   } trig_state_t;

endpackage
